// File: mem_pkg.sv
// memory stage shared definitions
package mem_pkg;

  localparam int WORD_WD     = 64;
  localparam int GPR_ADDR_WD = 5;
  localparam int RAM_ADDR_WD = 8;                     // word address, 256 words
  localparam int RAM_DEPTH   = 2 ** RAM_ADDR_WD;
  localparam int RAM_WAIT    = 3;                     // wait states before ack
  localparam int WAIT_CNT_WD = $clog2(RAM_WAIT + 1);

  // load/store funct3
  localparam logic [2:0] MEM_B  = 3'b000;
  localparam logic [2:0] MEM_H  = 3'b001;
  localparam logic [2:0] MEM_W  = 3'b010;
  localparam logic [2:0] MEM_D  = 3'b011;
  localparam logic [2:0] MEM_BU = 3'b100;
  localparam logic [2:0] MEM_HU = 3'b101;
  localparam logic [2:0] MEM_WU = 3'b110;

  typedef union packed {
    logic [WORD_WD/8-1:0][7:0]   bytes;
    logic [WORD_WD/16-1:0][15:0] halves;
    logic [WORD_WD/32-1:0][31:0] words;
  } ram_word_u;

  typedef struct packed {
    logic [GPR_ADDR_WD-1:0] rd;
    logic                   gpr_wen;
    logic                   mem_ren;
    logic                   mem_wen;
    logic [2:0]             mem_op;
    logic                   csr_inst_sel;  // gpr gets csrrdata
    logic [WORD_WD-1:0]     csrrdata;
    logic [WORD_WD-1:0]     alu_result;    // address for loads/stores
    logic [WORD_WD-1:0]     store_data;
  } es_to_ms_t;

  typedef struct packed {
    logic                   gpr_wen;
    logic [GPR_ADDR_WD-1:0] rd;
    logic [WORD_WD-1:0]     gpr_result;
  } ms_to_ws_t;

  typedef struct packed {
    logic                   wen;
    logic [GPR_ADDR_WD-1:0] rd;
    logic [WORD_WD-1:0]     value;
    logic                   pending;       // load still in flight
  } bypass_t;

  typedef struct packed {
    logic [RAM_ADDR_WD-1:0] addr;
    logic                   wen;
    logic [WORD_WD/8-1:0]   wstrb;
    ram_word_u              wdata;
  } ram_req_t;

endpackage

// File: wait_timer.sv
// ram wait-state timer
`timescale 1ns/1ps

module wait_timer import mem_pkg::*; (
  input  logic i_clk,
  input  logic i_rst_n,
  input  logic i_start,
  output logic o_expired
);

  logic                   run;
  logic [WAIT_CNT_WD-1:0] count;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      run   <= 1'b0;
      count <= '0;
    end else if (i_start) begin
      run   <= 1'b1;
      count <= WAIT_CNT_WD'(RAM_WAIT - 1);  // expiry lands RAM_WAIT cycles after start
    end else if (run) begin
      if (count == '0) begin
        run <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  assign o_expired = run && (count == '0);

  a_no_restart: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_start |-> !run)
    else $error("wait_timer started while running");

endmodule

// File: data_ram.sv
// data ram with req/ack port
`timescale 1ns/1ps

module data_ram import mem_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_req,
  input  ram_req_t  i_ram_req,
  output logic      o_ack,
  output ram_word_u o_rdata
);

  typedef enum logic [1:0] {R_IDLE, R_WAIT, R_ACK, R_RELEASE} state_e;

  state_e    state;
  state_e    state_nxt;
  logic      timer_start;
  logic      expired;
  logic      access;
  ram_word_u mem [RAM_DEPTH];
  ram_word_u rdata_q;

  assign timer_start = (state == R_IDLE) && i_req;
  assign access      = (state == R_WAIT) && expired;  // ack rises on this edge

  wait_timer u_wait_timer (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_start   (timer_start),
    .o_expired (expired)
  );

  always_comb begin
    state_nxt = state;
    case (state)
      R_IDLE:    if (i_req) state_nxt = R_WAIT;
      R_WAIT:    if (expired) state_nxt = R_ACK;
      R_ACK:     if (!i_req) state_nxt = R_RELEASE;
      R_RELEASE: state_nxt = R_IDLE;   // ack low for a cycle
      default:   state_nxt = R_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state <= R_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge i_clk) begin
    if (access) begin
      if (i_ram_req.wen) begin
        for (int i = 0; i < WORD_WD / 8; i++) begin
          if (i_ram_req.wstrb[i]) begin
            mem[i_ram_req.addr].bytes[i] <= i_ram_req.wdata.bytes[i];
          end
        end
      end else begin
        rdata_q <= mem[i_ram_req.addr];
      end
    end
  end

  assign o_ack   = (state == R_ACK);
  assign o_rdata = rdata_q;

  a_req_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_req && $past(i_req) |-> $stable(i_ram_req))
    else $error("ram request changed while req high");

endmodule

// File: mem_access_fsm.sv
// memory access sequencer
`timescale 1ns/1ps

module mem_access_fsm import mem_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_start,
  input  logic      i_advance,
  output logic      o_req,
  input  logic      i_ack,
  input  ram_word_u i_rdata,
  output ram_word_u o_rdata,
  output logic      o_done
);

  typedef enum logic [1:0] {IDLE, REQ, RELEASE, DONE} state_e;

  state_e    state;
  state_e    state_nxt;
  ram_word_u rdata_q;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (i_start) state_nxt = REQ;
      REQ:     if (i_ack) state_nxt = RELEASE;
      RELEASE: if (!i_ack) state_nxt = DONE;
      DONE:    if (i_advance) state_nxt = IDLE;  // held here under back-pressure
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge i_clk) begin
    if ((state == REQ) && i_ack) begin
      rdata_q <= i_rdata;
    end
  end

  assign o_req   = (state == REQ);
  assign o_done  = (state == DONE);
  assign o_rdata = rdata_q;

  a_ack_after_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_ack) |-> o_req)
    else $error("ack rose without req");

  a_ack_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $fell(i_ack) |-> !$past(o_req))
    else $error("ack dropped while req high");

endmodule

// File: lsu_store.sv
// store lane and strobe builder
`timescale 1ns/1ps

module lsu_store import mem_pkg::*; (
  input  logic [2:0]           i_addr_low,
  input  logic [2:0]           i_mem_op,
  input  logic [WORD_WD-1:0]   i_store_data,
  output logic [WORD_WD/8-1:0] o_wstrb,
  output ram_word_u            o_wdata
);

  always_comb begin
    o_wdata = '0;
    case (i_mem_op)
      MEM_B, MEM_BU: begin
        o_wdata.bytes = {(WORD_WD / 8){i_store_data[7:0]}};
        o_wstrb       = 8'b0000_0001 << i_addr_low;
      end
      MEM_H, MEM_HU: begin
        o_wdata.halves = {(WORD_WD / 16){i_store_data[15:0]}};
        o_wstrb        = 8'b0000_0011 << {i_addr_low[2:1], 1'b0};
      end
      MEM_W, MEM_WU: begin
        o_wdata.words = {(WORD_WD / 32){i_store_data[31:0]}};
        o_wstrb       = 8'b0000_1111 << {i_addr_low[2], 2'b00};
      end
      default: begin
        o_wdata = i_store_data;  // double, all lanes
        o_wstrb = '1;
      end
    endcase
  end

endmodule

// File: lsu_load.sv
// load align and extend
`timescale 1ns/1ps

module lsu_load import mem_pkg::*; (
  input  logic [2:0]         i_addr_low,
  input  logic [2:0]         i_mem_op,
  input  ram_word_u          i_rdata,
  output logic [WORD_WD-1:0] o_load_data
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic [31:0] word_sel;

  // lane picks through the union views
  assign byte_sel = i_rdata.bytes[i_addr_low];
  assign half_sel = i_rdata.halves[i_addr_low[2:1]];
  assign word_sel = i_rdata.words[i_addr_low[2]];

  always_comb begin
    case (i_mem_op)
      MEM_B:   o_load_data = {{(WORD_WD - 8){byte_sel[7]}}, byte_sel};
      MEM_BU:  o_load_data = {{(WORD_WD - 8){1'b0}}, byte_sel};
      MEM_H:   o_load_data = {{(WORD_WD - 16){half_sel[15]}}, half_sel};
      MEM_HU:  o_load_data = {{(WORD_WD - 16){1'b0}}, half_sel};
      MEM_W:   o_load_data = {{(WORD_WD - 32){word_sel[31]}}, word_sel};
      MEM_WU:  o_load_data = {{(WORD_WD - 32){1'b0}}, word_sel};
      MEM_D:   o_load_data = i_rdata;
      default: o_load_data = '0;  // no such load
    endcase
  end

endmodule

// File: mem_stage.sv
// memory stage control and result select
`timescale 1ns/1ps

module mem_stage import mem_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_es_to_ms_valid,
  input  es_to_ms_t          i_es_to_ms_bus,
  output logic               o_ms_allowin,
  input  logic               i_ws_allowin,
  output logic               o_ms_to_ws_valid,
  output ms_to_ws_t          o_ms_to_ws_bus,
  output bypass_t            o_ms_bypass,
  output logic               o_mem_start,
  output logic               o_advance,
  input  logic               i_mem_done,
  input  logic [WORD_WD-1:0] i_load_data,
  output es_to_ms_t          o_es_to_ms_r
);

  logic               ms_valid;
  logic               ms_ready_go;
  logic               ms_mem_inst;
  logic               misaligned;
  logic [WORD_WD-1:0] gpr_result;
  es_to_ms_t          es_to_ms_r;

  assign ms_mem_inst      = es_to_ms_r.mem_ren || es_to_ms_r.mem_wen;
  assign ms_ready_go      = !ms_mem_inst || i_mem_done;
  assign o_ms_allowin     = !ms_valid || (ms_ready_go && i_ws_allowin);
  assign o_ms_to_ws_valid = ms_valid && ms_ready_go;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ms_valid <= 1'b0;
    end else if (o_ms_allowin) begin
      ms_valid <= i_es_to_ms_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_es_to_ms_valid && o_ms_allowin) begin
      es_to_ms_r <= i_es_to_ms_bus;
    end
  end

  assign o_es_to_ms_r = es_to_ms_r;
  assign o_mem_start  = ms_valid && ms_mem_inst;
  assign o_advance    = o_ms_to_ws_valid && i_ws_allowin;  // handoff to ws

  assign gpr_result = es_to_ms_r.mem_ren      ? i_load_data
                    : es_to_ms_r.csr_inst_sel ? es_to_ms_r.csrrdata
                    :                           es_to_ms_r.alu_result;

  always_comb begin
    o_ms_to_ws_bus.gpr_wen    = es_to_ms_r.gpr_wen;
    o_ms_to_ws_bus.rd         = es_to_ms_r.rd;
    o_ms_to_ws_bus.gpr_result = gpr_result;
  end

  // forward to decode, load result not usable until done
  always_comb begin
    o_ms_bypass.wen     = ms_valid && es_to_ms_r.gpr_wen;
    o_ms_bypass.rd      = o_ms_bypass.wen ? es_to_ms_r.rd : '0;
    o_ms_bypass.value   = o_ms_bypass.wen ? gpr_result : '0;
    o_ms_bypass.pending = o_ms_bypass.wen && es_to_ms_r.mem_ren && !i_mem_done;
  end

  always_comb begin
    case (es_to_ms_r.mem_op)
      MEM_H, MEM_HU: misaligned = es_to_ms_r.alu_result[0];
      MEM_W, MEM_WU: misaligned = |es_to_ms_r.alu_result[1:0];
      MEM_D:         misaligned = |es_to_ms_r.alu_result[2:0];
      default:       misaligned = 1'b0;
    endcase
  end

  a_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_mem_start |-> !misaligned)
    else $error("misaligned memory access");

endmodule

// File: mem_subsys_top.sv
// memory stage with data ram
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_es_to_ms_valid,
  input  es_to_ms_t i_es_to_ms_bus,
  output logic      o_ms_allowin,
  input  logic      i_ws_allowin,
  output logic      o_ms_to_ws_valid,
  output ms_to_ws_t o_ms_to_ws_bus,
  output bypass_t   o_ms_bypass
);

  es_to_ms_t          es_to_ms_r;
  logic               mem_start;
  logic               advance;
  logic               mem_done;
  logic               req;
  logic               ack;
  logic [WORD_WD-1:0] load_data;
  ram_word_u          ram_rdata;
  ram_word_u          held_rdata;
  ram_req_t           ram_req;

  assign ram_req.addr = es_to_ms_r.alu_result[RAM_ADDR_WD+2:3];  // byte to word address
  assign ram_req.wen  = es_to_ms_r.mem_wen;

  mem_stage u_mem_stage (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_es_to_ms_valid (i_es_to_ms_valid),
    .i_es_to_ms_bus   (i_es_to_ms_bus),
    .o_ms_allowin     (o_ms_allowin),
    .i_ws_allowin     (i_ws_allowin),
    .o_ms_to_ws_valid (o_ms_to_ws_valid),
    .o_ms_to_ws_bus   (o_ms_to_ws_bus),
    .o_ms_bypass      (o_ms_bypass),
    .o_mem_start      (mem_start),
    .o_advance        (advance),
    .i_mem_done       (mem_done),
    .i_load_data      (load_data),
    .o_es_to_ms_r     (es_to_ms_r)
  );

  mem_access_fsm u_mem_access_fsm (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_start   (mem_start),
    .i_advance (advance),
    .o_req     (req),
    .i_ack     (ack),
    .i_rdata   (ram_rdata),
    .o_rdata   (held_rdata),
    .o_done    (mem_done)
  );

  lsu_store u_lsu_store (
    .i_addr_low   (es_to_ms_r.alu_result[2:0]),
    .i_mem_op     (es_to_ms_r.mem_op),
    .i_store_data (es_to_ms_r.store_data),
    .o_wstrb      (ram_req.wstrb),
    .o_wdata      (ram_req.wdata)
  );

  lsu_load u_lsu_load (
    .i_addr_low  (es_to_ms_r.alu_result[2:0]),
    .i_mem_op    (es_to_ms_r.mem_op),
    .i_rdata     (held_rdata),
    .o_load_data (load_data)
  );

  data_ram u_data_ram (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_req     (req),
    .i_ram_req (ram_req),
    .o_ack     (ack),
    .o_rdata   (ram_rdata)
  );

endmodule

// File: tb_mem_subsys.sv
// memory stage testbench
`timescale 1ns/1ps

module tb_mem_subsys import mem_pkg::*; ();

  localparam int TIMEOUT = 40;                 // cycles per wait
  localparam int MEM_LAT = 1 + RAM_WAIT + 4;   // idle ram

  logic      clk;
  logic      rst_n;
  logic      es_valid;
  es_to_ms_t es_bus;
  logic      ms_allowin;
  logic      ws_allowin;
  logic      ws_valid;
  ms_to_ws_t ws_bus;
  bypass_t   bypass;

  logic [7:0]  model_mem [RAM_DEPTH * 8];      // byte addressed
  logic [31:0] lfsr;
  logic [2:0]  load_ops [7];
  int          errors;
  int          checks;
  int          test_errors;
  bit          hung;

  mem_subsys_top u_mem_subsys_top (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_es_to_ms_valid (es_valid),
    .i_es_to_ms_bus   (es_bus),
    .o_ms_allowin     (ms_allowin),
    .i_ws_allowin     (ws_allowin),
    .o_ms_to_ws_valid (ws_valid),
    .o_ms_to_ws_bus   (ws_bus),
    .o_ms_bypass      (bypass)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic int op_size(input logic [2:0] op);
    case (op)
      MEM_B, MEM_BU: return 1;
      MEM_H, MEM_HU: return 2;
      MEM_W, MEM_WU: return 4;
      default:       return 8;
    endcase
  endfunction

  function automatic void model_store(input int addr, input logic [2:0] op,
                                      input logic [63:0] data);
    for (int i = 0; i < op_size(op); i++) begin
      model_mem[addr + i] = data[8*i +: 8];  // little endian
    end
  endfunction

  function automatic logic [63:0] model_load(input int addr, input logic [2:0] op);
    logic [63:0] v;
    int          n;
    n = op_size(op);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = model_mem[addr + i];
    end
    if ((op == MEM_B || op == MEM_H || op == MEM_W) && v[8*n-1]) begin
      v = v | ~((64'd1 << (8 * n)) - 64'd1);  // sign fill
    end
    return v;
  endfunction

  function automatic es_to_ms_t mem_bus(input bit wr, input int addr, input logic [2:0] op,
                                        input logic [4:0] rd, input logic [63:0] data);
    es_to_ms_t b;
    b            = '0;
    b.rd         = rd;
    b.gpr_wen    = !wr;
    b.mem_ren    = !wr;
    b.mem_wen    = wr;
    b.mem_op     = op;
    b.alu_result = 64'(addr);
    b.store_data = data;
    return b;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_hang(input string what);
    $display("ERROR: timed out waiting for %s", what);
    hung = 1'b1;
    errors++;
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  // hold the bundle until the stage takes it
  task automatic accept(input es_to_ms_t bus);
    int cycles;
    es_valid = 1'b1;
    es_bus   = bus;
    cycles   = 0;
    while (!ms_allowin && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!ms_allowin) begin
      report_hang("stage allowin");
    end
    @(posedge clk);
    #1;
    es_valid = 1'b0;
  endtask

  task automatic wait_output(output ms_to_ws_t res, output int lat);
    lat = 0;
    while (!ws_valid && lat < TIMEOUT) begin
      @(posedge clk);
      #1;
      lat++;
    end
    if (!ws_valid) begin
      report_hang("output valid");
    end
    res = ws_bus;
  endtask

  task automatic do_store(input int addr, input logic [2:0] op, input logic [63:0] data);
    ms_to_ws_t res;
    int        lat;
    model_store(addr, op, data);
    accept(mem_bus(1'b1, addr, op, 5'd0, data));
    wait_output(res, lat);
    check_value("store_gpr_wen", 64'd0, 64'(res.gpr_wen));
  endtask

  task automatic do_load(input string name, input int addr, input logic [2:0] op,
                         output int lat);
    ms_to_ws_t res;
    accept(mem_bus(1'b0, addr, op, 5'd9, '0));
    wait_output(res, lat);
    check_value(name, model_load(addr, op), res.gpr_result);
  endtask

  task automatic test_reset();
    check_value("reset_valid", 64'd0, 64'(ws_valid));
    check_value("reset_bypass_wen", 64'd0, 64'(bypass.wen));
    check_value("reset_allowin", 64'd1, 64'(ms_allowin));
    end_test("reset");
  endtask

  task automatic test_passthrough();
    es_to_ms_t b;
    ms_to_ws_t res;
    int        lat;
    b            = '0;
    b.rd         = 5'd5;
    b.gpr_wen    = 1'b1;
    b.alu_result = 64'h1234_5678_9abc_def0;
    b.csrrdata   = 64'h0bad_cafe_0000_0001;
    accept(b);
    wait_output(res, lat);
    check_value("alu_result", b.alu_result, res.gpr_result);
    check_value("alu_rd", 64'(b.rd), 64'(res.rd));
    check_value("alu_gpr_wen", 64'd1, 64'(res.gpr_wen));
    check_value("alu_latency", 64'd0, 64'(lat));
    b.csr_inst_sel = 1'b1;
    accept(b);
    wait_output(res, lat);
    check_value("csr_result", b.csrrdata, res.gpr_result);
    check_value("csr_latency", 64'd0, 64'(lat));
    end_test("passthrough");
  endtask

  task automatic test_store_load();
    int lat;
    do_store(0, MEM_D, 64'h8123_4567_89ab_cdef);
    do_store(8, MEM_D, 64'h7f6e_5d4c_3b2a_1908);
    do_store(16, MEM_D, 64'hfedc_ba98_7654_3210);
    do_store(4, MEM_W, 64'h1111_2222_f00d_cafe);
    do_store(2, MEM_H, 64'h3333_4444_5555_9abc);
    do_store(1, MEM_B, 64'h6666_7777_8888_9980);
    do_store(14, MEM_H, 64'h0000_0000_0000_8001);
    do_store(9, MEM_B, 64'h0000_0000_0000_00f3);
    for (int w = 0; w < 16; w += 8) begin
      foreach (load_ops[k]) begin
        for (int off = 0; off < 8; off += op_size(load_ops[k])) begin
          do_load("store_load", w + off, load_ops[k], lat);
          check_value("store_load_latency", 64'(MEM_LAT), 64'(lat));
        end
      end
    end
    end_test("store_load");
  endtask

  task automatic test_backpressure();
    ms_to_ws_t held;
    int        lat;
    @(posedge clk);  // previous result leaves
    #1;
    ws_allowin = 1'b0;
    accept(mem_bus(1'b0, 16, MEM_W, 5'd12, '0));
    wait_output(held, lat);
    for (int i = 0; i < 6; i++) begin
      @(posedge clk);
      #1;
      check_value("bp_valid", 64'd1, 64'(ws_valid));
      check_value("bp_result", model_load(16, MEM_W), ws_bus.gpr_result);
      check_value("bp_allowin", 64'd0, 64'(ms_allowin));
    end
    ws_allowin = 1'b1;
    @(posedge clk);
    #1;
    check_value("bp_handoff_once", 64'd0, 64'(ws_valid));
    check_value("bp_data", model_load(16, MEM_W), held.gpr_result);
    do_load("bp_next_load", 20, MEM_WU, lat);
    end_test("backpressure");
  endtask

  task automatic test_bypass();
    es_to_ms_t b;
    ms_to_ws_t res;
    int        lat;
    accept(mem_bus(1'b0, 8, MEM_D, 5'd17, '0));
    check_value("bypass_load_pending", 64'd1, 64'(bypass.pending));
    check_value("bypass_load_rd", 64'd17, 64'(bypass.rd));
    wait_output(res, lat);
    check_value("bypass_load_done", 64'd0, 64'(bypass.pending));
    check_value("bypass_load_value", model_load(8, MEM_D), bypass.value);
    b            = '0;
    b.rd         = 5'd3;
    b.gpr_wen    = 1'b1;
    b.alu_result = 64'h0000_0000_dead_0003;
    accept(b);
    check_value("bypass_alu_pending", 64'd0, 64'(bypass.pending));
    check_value("bypass_alu_wen", 64'd1, 64'(bypass.wen));
    check_value("bypass_alu_value", b.alu_result, bypass.value);
    wait_output(res, lat);
    end_test("bypass");
  endtask

  task automatic test_random();
    logic [63:0] r;
    logic [2:0]  op;
    logic [2:0]  idx;
    bit          store;
    int          addr;
    int          lat;
    for (int w = 0; w < 8; w++) begin
      do_store(256 + 8 * w, MEM_D, rand_bits(64));  // region words 32..39
    end
    for (int n = 0; n < 40; n++) begin
      r     = rand_bits(1);
      store = r[0];
      if (store) begin
        r  = rand_bits(2);
        op = {1'b0, r[1:0]};
      end else begin
        r   = rand_bits(3);
        idx = (r[2:0] == 3'd7) ? 3'd3 : r[2:0];
        op  = load_ops[idx];
      end
      r    = rand_bits(3);
      addr = 256 + 8 * int'(r[2:0]);
      r    = rand_bits(3);
      addr = addr + (int'(r[2:0]) & ~(op_size(op) - 1));  // aligned offset
      if (store) begin
        do_store(addr, op, rand_bits(64));
      end else begin
        do_load("random_load", addr, op, lat);
      end
    end
    end_test("random");
  endtask

  initial begin
    rst_n       = 1'b0;
    es_valid    = 1'b0;
    es_bus      = '0;
    ws_allowin  = 1'b1;
    lfsr        = 32'h4440_fa44;
    errors      = 0;
    checks      = 0;
    test_errors = 0;
    hung        = 1'b0;
    load_ops    = '{MEM_B, MEM_H, MEM_W, MEM_D, MEM_BU, MEM_HU, MEM_WU};
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    if (!hung) test_passthrough();
    if (!hung) test_store_load();
    if (!hung) test_backpressure();
    if (!hung) test_bypass();
    if (!hung) test_random();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && !hung) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: project.f
mem_pkg.sv
wait_timer.sv
data_ram.sv
mem_access_fsm.sv
lsu_store.sv
lsu_load.sv
mem_stage.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// File: run.sh
#!/bin/sh
# build and run the memory stage testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mem_subsys -Mdir "$OBJ" -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build error"
  exit 1
fi

"./$OBJ/Vtb_mem_subsys" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
